// File: run.sh
#!/bin/sh
# build with verilator, then judge the run by its output
verilator --binary --timing -f vlog.f --top-module tb_uart_cmd -o sim_uart_cmd \
  || exit 1
out=$(./obj_dir/sim_uart_cmd 2>&1)
echo "$out"
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1

// File: src/uart_cmd_seq.sv
`timescale 1ns/100ps

module uart_cmd_seq (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  uart_tx_if.ctrl         tx_link,
  input  logic            rx_valid,
  input  uart_pkg::byte_t rx_data,
  input  logic            rx_parity_err,
  output logic            read_rdy,
  output uart_pkg::read_t read_data
);

  typedef enum logic [2:0] {
    IDLE,
    SEND_HIGH,
    SEND_LOW,
    WAIT_RESP,
    FINISH
  } state_t;

  state_t          state;
  uart_pkg::cmd_t  cmd_q;
  uart_pkg::byte_t tx_data;
  logic            tx_start;
  logic            accept;

  // ready again already in finish, so back-to-back commands lose no cycle
  // start only goes out while the serializer is idle
  assign cmd_rdy = ((state == IDLE) || (state == FINISH)) && !tx_link.busy;
  assign accept  = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
    end else begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        IDLE, FINISH: begin
          if (accept) begin
            state    <= SEND_HIGH;
            tx_start <= 1'b1;
          end else begin
            state <= IDLE;
          end
        end
        SEND_HIGH: begin
          if (tx_link.done) begin
            if (cmd_q.rw) begin
              state <= WAIT_RESP;
            end else begin
              state    <= SEND_LOW;
              tx_start <= 1'b1;
            end
          end
        end
        SEND_LOW: begin
          if (tx_link.done) begin
            state <= FINISH;
          end
        end
        WAIT_RESP: begin
          // a missing answer stalls here
          if (rx_valid) begin
            state    <= FINISH;
            read_rdy <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // payload registers
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q   <= cmd_in;
      tx_data <= {cmd_in.rw, cmd_in.addr};
    end else if ((state == SEND_HIGH) && tx_link.done) begin
      tx_data <= cmd_q.data;
    end
    if ((state == WAIT_RESP) && rx_valid) begin
      read_data <= {rx_parity_err, rx_data};
    end
  end

  assign tx_link.start = tx_start;
  assign tx_link.data  = tx_data;

endmodule

// File: src/uart_cmd_top.sv
`timescale 1ns/100ps

module uart_cmd_top (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  input  logic            rx,
  output logic            tx,
  output logic            read_rdy,
  output uart_pkg::read_t read_data
);

  uart_tx_if tx_link ();

  // receive link to the sequencer
  logic            rx_valid;
  uart_pkg::byte_t rx_data;
  logic            rx_parity_err;

  uart_cmd_seq u_seq (
    .clk           (clk),
    .rst_n         (rst_n),
    .cmd_in        (cmd_in),
    .cmd_vld       (cmd_vld),
    .cmd_rdy       (cmd_rdy),
    .tx_link       (tx_link.ctrl),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .rx_parity_err (rx_parity_err),
    .read_rdy      (read_rdy),
    .read_data     (read_data)
  );

  uart_tx u_tx (
    .clk   (clk),
    .rst_n (rst_n),
    .link  (tx_link.engine),
    .tx    (tx)
  );

  uart_rx u_rx (
    .clk           (clk),
    .rst_n         (rst_n),
    .rx            (rx),
    .rx_valid      (rx_valid),
    .rx_data       (rx_data),
    .rx_parity_err (rx_parity_err)
  );

endmodule

// File: src/uart_pkg.sv
package uart_pkg;

  localparam int CMD_WIDTH  = 16;
  localparam int BYTE_WIDTH = 8;
  // address field fills what the rw flag and data byte leave over
  localparam int ADDR_WIDTH = CMD_WIDTH - BYTE_WIDTH - 1;

  // kept small so simulation stays short
  localparam int CLKS_PER_BIT = 8;
  localparam int HALF_BIT     = CLKS_PER_BIT / 2;

  // start + 8 data + parity + stop
  localparam int FRAME_BITS = 11;

  localparam int TICK_W = $clog2(CLKS_PER_BIT);
  localparam int BIT_W  = $clog2(FRAME_BITS);

  typedef logic [BYTE_WIDTH-1:0] byte_t;

  // bit 15 rw, 14:8 addr, 7:0 data
  typedef struct packed {
    logic                  rw;
    logic [ADDR_WIDTH-1:0] addr;
    byte_t                 data;
  } cmd_t;

  typedef struct packed {
    logic  parity_err;
    byte_t data;
  } read_t;

endpackage

// File: src/uart_rx.sv
`timescale 1ns/100ps

module uart_rx (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            rx,
  output logic            rx_valid,
  output uart_pkg::byte_t rx_data,
  output logic            rx_parity_err
);

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
  } state_t;

  state_t                      state;
  logic                        rx_meta;
  logic                        rx_sync;
  logic                        rx_prev;
  logic [uart_pkg::TICK_W-1:0] tick_cnt;
  logic [uart_pkg::BIT_W-1:0]  bit_cnt;
  logic                        tick_last;
  logic                        half_tick;
  logic                        parity_acc;
  uart_pkg::byte_t             data_sr;

  // two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign tick_last = (tick_cnt == uart_pkg::TICK_W'(uart_pkg::CLKS_PER_BIT - 1));
  assign half_tick = (tick_cnt == uart_pkg::TICK_W'(uart_pkg::HALF_BIT - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (rx_prev && !rx_sync) begin
            state    <= START;
            tick_cnt <= '0;
          end
        end
        START: begin
          if (half_tick) begin
            // line back high at mid start bit means a glitch
            if (rx_sync) begin
              state <= IDLE;
            end else begin
              state    <= DATA;
              tick_cnt <= '0;
              bit_cnt  <= '0;
            end
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        DATA: begin
          if (tick_last) begin
            tick_cnt <= '0;
            if (bit_cnt == uart_pkg::BIT_W'(uart_pkg::BYTE_WIDTH - 1)) begin
              state <= PARITY;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        PARITY: begin
          if (tick_last) begin
            tick_cnt <= '0;
            state    <= STOP;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        STOP: begin
          if (tick_last) begin
            tick_cnt <= '0;
            state    <= IDLE;
            // bad stop bit drops the frame
            rx_valid <= rx_sync;
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // payload sampling, lsb arrives first
  always_ff @(posedge clk) begin
    if (state == START) begin
      parity_acc <= 1'b0;
    end else if ((state == DATA) && tick_last) begin
      data_sr    <= {rx_sync, data_sr[uart_pkg::BYTE_WIDTH-1:1]};
      parity_acc <= parity_acc ^ rx_sync;
    end else if ((state == PARITY) && tick_last) begin
      parity_acc <= parity_acc ^ rx_sync;
    end
  end

  // odd parity over data and parity bit
  always_ff @(posedge clk) begin
    if ((state == STOP) && tick_last) begin
      rx_parity_err <= ~parity_acc;
    end
  end

  assign rx_data = data_sr;

endmodule

// File: src/uart_tx.sv
`timescale 1ns/100ps

module uart_tx (
  input  logic      clk,
  input  logic      rst_n,
  uart_tx_if.engine link,
  output logic      tx
);

  logic                           busy;
  logic [uart_pkg::FRAME_BITS-1:0] frame_sr;
  logic [uart_pkg::TICK_W-1:0]     tick_cnt;
  logic [uart_pkg::BIT_W-1:0]      bit_cnt;
  logic                           tick_last;
  logic                           bit_last;

  assign tick_last = (tick_cnt == uart_pkg::TICK_W'(uart_pkg::CLKS_PER_BIT - 1));
  assign bit_last  = (bit_cnt == uart_pkg::BIT_W'(uart_pkg::FRAME_BITS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      frame_sr <= '1;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else if (!busy) begin
      if (link.start) begin
        busy     <= 1'b1;
        // stop, odd parity, data lsb first, start
        frame_sr <= {1'b1, ~^link.data, link.data, 1'b0};
        tick_cnt <= '0;
        bit_cnt  <= '0;
      end
    end else if (tick_last) begin
      tick_cnt <= '0;
      // shift in ones so the line idles high afterwards
      frame_sr <= {1'b1, frame_sr[uart_pkg::FRAME_BITS-1:1]};
      if (bit_last) begin
        busy    <= 1'b0;
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // done in the last cycle of the stop bit
  assign link.done = busy & bit_last & tick_last;
  assign link.busy = busy;

  assign tx = frame_sr[0];

endmodule

// File: src/uart_tx_if.sv
`timescale 1ns/100ps

interface uart_tx_if;

  logic            start;
  uart_pkg::byte_t data;
  logic            busy;
  logic            done;

  // sequencer side
  modport ctrl (
    output start,
    output data,
    input  busy,
    input  done
  );

  // serializer side
  modport engine (
    input  start,
    input  data,
    output busy,
    output done
  );

endinterface

// File: test/tb_uart_cmd.sv
`timescale 1ns/100ps

module tb_uart_cmd;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 16;
  localparam int CPB          = uart_pkg::CLKS_PER_BIT;
  localparam int FRAME_CYCLES = uart_pkg::FRAME_BITS * CPB;
  localparam int N_ENTRIES    = 8;
  // at most four frames per entry plus reset and slack
  localparam longint TIMEOUT_NS =
    longint'(N_ENTRIES * 4 * FRAME_CYCLES + RESET_CYCLES + 2000) * CLK_PERIOD;

  typedef struct packed {
    uart_pkg::cmd_t  cmd;
    uart_pkg::byte_t resp;
    uart_pkg::byte_t stray_byte;
    logic            bad_par;
    logic            glitch;
    logic            stray;
    logic            extra_vld;
    uart_pkg::byte_t exp_hi;
    uart_pkg::byte_t exp_lo;
    uart_pkg::read_t exp_read;
  } entry_t;

  logic            clk;
  logic            rst_n;
  uart_pkg::cmd_t  cmd_in;
  logic            cmd_vld;
  logic            cmd_rdy;
  logic            rx;
  logic            tx;
  logic            read_rdy;
  uart_pkg::read_t read_data;

  integer          seed = 32'hc7480fd9;
  entry_t          tbl [N_ENTRIES];
  uart_pkg::byte_t tx_bytes [$];

  uart_cmd_top u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic uart_pkg::byte_t rand_byte();
    return uart_pkg::byte_t'($random(seed));
  endfunction

  function automatic entry_t make_entry(logic rw, logic [uart_pkg::ADDR_WIDTH-1:0] addr,
      uart_pkg::byte_t data, uart_pkg::byte_t resp, logic bad_par, logic glitch,
      logic stray, logic extra_vld);
    entry_t e;
    e.cmd.rw     = rw;
    e.cmd.addr   = addr;
    e.cmd.data   = data;
    e.resp       = resp;
    e.stray_byte = rand_byte();
    e.bad_par    = bad_par;
    e.glitch     = glitch;
    e.stray      = stray;
    e.extra_vld  = extra_vld;
    // high frame carries rw and address
    e.exp_hi     = {rw, addr};
    e.exp_lo     = data;
    e.exp_read.parity_err = bad_par;
    e.exp_read.data       = resp;
    return e;
  endfunction

  task automatic stop_run(string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_byte(string name, uart_pkg::byte_t exp, uart_pkg::byte_t got);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %s expected 0x%h actual 0x%h", name, exp, got));
    end
  endtask

  task automatic check_read(string name, uart_pkg::read_t exp, uart_pkg::read_t got);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %s expected 0x%h actual 0x%h", name, exp, got));
    end
  endtask

  task automatic check_bit(string name, logic exp, logic got);
    if (got !== exp) begin
      stop_run($sformatf("ERROR %s expected 0x%h actual 0x%h", name, exp, got));
    end
  endtask

  task automatic check_tx_byte(uart_pkg::byte_t exp);
    uart_pkg::byte_t got;
    if (tx_bytes.size() == 0) begin
      stop_run("no frame was captured on tx");
    end
    got = tx_bytes.pop_front();
    check_byte("tx", exp, got);
  endtask

  task automatic expect_idle(int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_bit("tx", 1'b1, tx);
      check_bit("cmd_rdy", 1'b1, cmd_rdy);
      check_bit("read_rdy", 1'b0, read_rdy);
    end
  endtask

  task automatic wait_cmd_rdy();
    int n;
    n = 0;
    @(negedge clk);
    while (!cmd_rdy) begin
      if (n == 4 * FRAME_CYCLES) begin
        stop_run("cmd_rdy did not return high");
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic wait_frames(int count);
    int n;
    n = 0;
    while (tx_bytes.size() < count) begin
      if (n == 2 * FRAME_CYCLES) begin
        stop_run("an expected frame never appeared on tx");
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic wait_read(uart_pkg::read_t exp);
    int n;
    n = 0;
    @(negedge clk);
    while (!read_rdy) begin
      if (n == 2 * FRAME_CYCLES) begin
        stop_run("read_rdy never came after the response frame");
      end
      n++;
      @(negedge clk);
    end
    check_read("read_data", exp, read_data);
    check_bit("cmd_rdy", 1'b1, cmd_rdy);
    @(negedge clk);
    check_bit("read_rdy", 1'b0, read_rdy);
  endtask

  task automatic issue_cmd(uart_pkg::cmd_t cmd);
    @(posedge clk);
    cmd_in  <= cmd;
    cmd_vld <= 1'b1;
    @(posedge clk);
    cmd_vld <= 1'b0;
    @(negedge clk);
    check_bit("cmd_rdy", 1'b0, cmd_rdy);
  endtask

  // response driver sends one odd-parity frame on rx
  task automatic send_frame(uart_pkg::byte_t b, logic flip_par);
    logic [uart_pkg::FRAME_BITS-1:0] bits;
    bits = {1'b1, (~^b) ^ flip_par, b, 1'b0};
    @(posedge clk);
    for (int i = 0; i < uart_pkg::FRAME_BITS; i++) begin
      rx <= bits[i];
      repeat (CPB) @(posedge clk);
    end
  endtask

  task automatic send_glitch();
    @(posedge clk);
    rx <= 1'b0;
    repeat (uart_pkg::HALF_BIT / 2) @(posedge clk);
    rx <= 1'b1;
    repeat (CPB) @(posedge clk);
  endtask

  // serial monitor samples tx near mid-bit
  initial begin : tx_monitor
    uart_pkg::byte_t data;
    logic            par;
    logic            stop;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge tx);
      repeat (uart_pkg::HALF_BIT) @(negedge clk);
      if (tx !== 1'b0) begin
        stop_run("start bit on tx did not stay low");
      end
      for (int i = 0; i < uart_pkg::BYTE_WIDTH; i++) begin
        repeat (CPB) @(negedge clk);
        data[i] = tx;
      end
      repeat (CPB) @(negedge clk);
      par = tx;
      repeat (CPB) @(negedge clk);
      stop = tx;
      if (^{par, data} !== 1'b1) begin
        stop_run("odd parity is wrong in a frame on tx");
      end
      if (stop !== 1'b1) begin
        stop_run("stop bit of a frame on tx is not high");
      end
      tx_bytes.push_back(data);
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    stop_run("watchdog expired before all table entries finished");
  end

  initial begin : main_seq
    entry_t         e;
    uart_pkg::cmd_t junk;
    rst_n   <= 1'b0;
    cmd_in  <= '0;
    cmd_vld <= 1'b0;
    rx      <= 1'b1;
    //                rw    addr   data         resp         bad   glitch stray extra
    tbl[0] = make_entry(1'b0, 7'h12, 8'ha5,       8'h00,       1'b0, 1'b0, 1'b0, 1'b0);
    tbl[1] = make_entry(1'b0, 7'h7f, rand_byte(), 8'h00,       1'b0, 1'b0, 1'b0, 1'b1);
    tbl[2] = make_entry(1'b1, 7'h05, 8'h00,       8'h3c,       1'b0, 1'b0, 1'b0, 1'b0);
    tbl[3] = make_entry(1'b1, 7'h40, 8'h00,       rand_byte(), 1'b1, 1'b0, 1'b0, 1'b0);
    tbl[4] = make_entry(1'b1, 7'h00, 8'h00,       8'h00,       1'b0, 1'b0, 1'b1, 1'b0);
    tbl[5] = make_entry(1'b1, 7'h2b, 8'h00,       8'hff,       1'b0, 1'b1, 1'b0, 1'b0);
    tbl[6] = make_entry(1'b0, 7'h55, 8'h00,       8'h00,       1'b0, 1'b0, 1'b0, 1'b1);
    tbl[7] = make_entry(1'b1, 7'h7e, rand_byte(), rand_byte(), 1'b1, 1'b1, 1'b1, 1'b0);
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    expect_idle(4 * CPB);
    for (int k = 0; k < N_ENTRIES; k++) begin
      e = tbl[k];
      wait_cmd_rdy();
      if (e.stray) begin
        // nothing pending, so this frame must vanish
        fork
          send_frame(e.stray_byte, 1'b0);
          expect_idle(FRAME_CYCLES + 2 * CPB);
        join
      end
      issue_cmd(e.cmd);
      wait_frames(1);
      check_tx_byte(e.exp_hi);
      if (e.cmd.rw) begin
        fork
          begin
            if (e.glitch) begin
              send_glitch();
            end
            send_frame(e.resp, e.bad_par);
          end
          wait_read(e.exp_read);
        join
      end else begin
        if (e.extra_vld) begin
          junk = {rand_byte(), rand_byte()};
          issue_cmd(junk);
        end
        wait_frames(1);
        check_tx_byte(e.exp_lo);
        wait_cmd_rdy();
      end
      expect_idle(2 * CPB);
      if (tx_bytes.size() != 0) begin
        stop_run("an unexpected extra frame appeared on tx");
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: vlog.f
src/uart_pkg.sv
src/uart_tx_if.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_cmd_seq.sv
src/uart_cmd_top.sv
test/tb_uart_cmd.sv
